/* Makefile */
# Verilator build and run for the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_yarc_periph_top
FILELIST  ?= yarc_periph_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN  = $(BUILD_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Regression passed" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/led_driver.sv */
// led status register with write, set and clear views
`timescale 1ns/1ps
`default_nettype none

module led_driver (
    input  wire                                    clk_i,
    input  wire                                    reset_i,

    // apb slave
    input  wire                                    psel_i,
    input  wire                                    penable_i,
    input  wire                                    pwrite_i,
    input  wire  [platform_pkg::PERIPH_OFFS_W-1:0] paddr_i,
    input  wire  [platform_pkg::PERIPH_DW-1:0]     pwdata_i,
    output logic [platform_pkg::PERIPH_DW-1:0]     prdata_o,
    output logic                                   pready_o,
    output logic                                   pslverr_o,

    output logic [7:0]                             led_status_o
);

    import periph_regs_pkg::*;

    logic access;
    logic wr_en;
    logic offs_valid;

    assign access   = psel_i & penable_i;
    assign wr_en    = access & pwrite_i;
    assign pready_o = access;

    // set and clear only touch bits written as one
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            led_status_o <= '0;
        end else if (wr_en) begin
            case (paddr_i)
                LED_OUT_OFFS: led_status_o <= pwdata_i[7:0];
                LED_SET_OFFS: led_status_o <= led_status_o | pwdata_i[7:0];
                LED_CLR_OFFS: led_status_o <= led_status_o & ~pwdata_i[7:0];
                default:      led_status_o <= led_status_o;
            endcase
        end
    end

    // every view reads the same value
    assign offs_valid = (paddr_i == LED_OUT_OFFS) || (paddr_i == LED_SET_OFFS)
                        || (paddr_i == LED_CLR_OFFS);

    always_comb begin
        prdata_o = '0;
        if (offs_valid) begin
            prdata_o[7:0] = led_status_o;
        end
    end

    assign pslverr_o = access & ~offs_valid;

endmodule : led_driver

`default_nettype wire

/* hw/mtimer.sv */
// 64-bit machine timer with prescaler, compare register
// and a level timer interrupt
`timescale 1ns/1ps
`default_nettype none

module mtimer #(
    parameter int unsigned TICK_DIV = 1
) (
    input  wire                                    clk_i,
    input  wire                                    reset_i,

    // apb slave
    input  wire                                    psel_i,
    input  wire                                    penable_i,
    input  wire                                    pwrite_i,
    input  wire  [platform_pkg::PERIPH_OFFS_W-1:0] paddr_i,
    input  wire  [platform_pkg::PERIPH_DW-1:0]     pwdata_i,
    output logic [platform_pkg::PERIPH_DW-1:0]     prdata_o,
    output logic                                   pready_o,
    output logic                                   pslverr_o,

    output logic                                   timer_int_o
);

    import periph_regs_pkg::*;

    localparam logic [31:0] TICK_LAST = 32'(TICK_DIV - 1);

    logic [31:0] tick_cnt_q;
    logic        tick;
    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        access;
    logic        wr_en;
    logic        offs_valid;

    assign access   = psel_i & penable_i;
    assign wr_en    = access & pwrite_i;
    assign pready_o = access;

    // prescaler, one tick every TICK_DIV clocks
    assign tick = (tick_cnt_q == TICK_LAST);

    always_ff @(posedge clk_i) begin
        if (reset_i || tick) begin
            tick_cnt_q <= '0;
        end else begin
            tick_cnt_q <= tick_cnt_q + 32'd1;
        end
    end

    // a bus write wins over the tick in the same cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtime_q <= '0;
        end else if (wr_en && paddr_i == MTIME_LO_OFFS) begin
            mtime_q[31:0] <= pwdata_i;
        end else if (wr_en && paddr_i == MTIME_HI_OFFS) begin
            mtime_q[63:32] <= pwdata_i;
        end else if (tick) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // all ones after reset keeps the interrupt quiet
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtimecmp_q <= '1;
        end else if (wr_en && paddr_i == MTIMECMP_LO_OFFS) begin
            mtimecmp_q[31:0] <= pwdata_i;
        end else if (wr_en && paddr_i == MTIMECMP_HI_OFFS) begin
            mtimecmp_q[63:32] <= pwdata_i;
        end
    end

    // level interrupt, one clock behind the compare
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            timer_int_o <= 1'b0;
        end else begin
            timer_int_o <= (mtime_q >= mtimecmp_q);
        end
    end

    // read mux
    always_comb begin
        prdata_o   = '0;
        offs_valid = 1'b1;
        case (paddr_i)
            MTIME_LO_OFFS:    prdata_o = mtime_q[31:0];
            MTIME_HI_OFFS:    prdata_o = mtime_q[63:32];
            MTIMECMP_LO_OFFS: prdata_o = mtimecmp_q[31:0];
            MTIMECMP_HI_OFFS: prdata_o = mtimecmp_q[63:32];
            default:          offs_valid = 1'b0;
        endcase
    end

    assign pslverr_o = access & ~offs_valid;

endmodule : mtimer

`default_nettype wire

/* hw/periph_regs_pkg.sv */
// register offsets and bit positions of the timer, led and uart blocks
`default_nettype none

package periph_regs_pkg;

    // machine timer, 64-bit values as two 32-bit halves
    localparam logic [platform_pkg::PERIPH_OFFS_W-1:0] MTIME_LO_OFFS    = 'h00;
    localparam logic [platform_pkg::PERIPH_OFFS_W-1:0] MTIME_HI_OFFS    = 'h04;
    localparam logic [platform_pkg::PERIPH_OFFS_W-1:0] MTIMECMP_LO_OFFS = 'h08;
    localparam logic [platform_pkg::PERIPH_OFFS_W-1:0] MTIMECMP_HI_OFFS = 'h0C;

    // led driver views of the one status register
    localparam logic [platform_pkg::PERIPH_OFFS_W-1:0] LED_OUT_OFFS = 'h00;
    localparam logic [platform_pkg::PERIPH_OFFS_W-1:0] LED_SET_OFFS = 'h04;
    localparam logic [platform_pkg::PERIPH_OFFS_W-1:0] LED_CLR_OFFS = 'h08;

    // uart transmitter
    localparam logic [platform_pkg::PERIPH_OFFS_W-1:0] UART_DATA_OFFS   = 'h00;
    localparam logic [platform_pkg::PERIPH_OFFS_W-1:0] UART_STATUS_OFFS = 'h04;
    localparam logic [platform_pkg::PERIPH_OFFS_W-1:0] UART_BAUD_OFFS   = 'h08;

    // status bits
    localparam int UART_STATUS_BUSY_BIT = 0;

endpackage : periph_regs_pkg

`default_nettype wire

/* hw/periph_xbar.sv */
// apb decoder from one master to the peripheral slaves,
// unmapped selects are answered here with an error
`timescale 1ns/1ps
`default_nettype none

module periph_xbar #(
    parameter int NUM_SLAVES = platform_pkg::PERIPH_XBAR_NUM_SLAVES
) (
    // master side
    input  wire  [platform_pkg::PERIPH_AW-1:0]    paddr_i,
    input  wire                                   psel_i,
    input  wire                                   penable_i,
    input  wire                                   pwrite_i,
    input  wire  [platform_pkg::PERIPH_DW-1:0]    pwdata_i,
    output logic [platform_pkg::PERIPH_DW-1:0]    prdata_o,
    output logic                                  pready_o,
    output logic                                  pslverr_o,

    // slave side
    output logic [NUM_SLAVES-1:0]                 s_psel_o,
    output logic [platform_pkg::PERIPH_OFFS_W-1:0] s_paddr_o,
    output logic                                  s_penable_o,
    output logic                                  s_pwrite_o,
    output logic [platform_pkg::PERIPH_DW-1:0]    s_pwdata_o,
    input  wire  [NUM_SLAVES-1:0][platform_pkg::PERIPH_DW-1:0] s_prdata_i,
    input  wire  [NUM_SLAVES-1:0]                 s_pready_i,
    input  wire  [NUM_SLAVES-1:0]                 s_pslverr_i
);

    import platform_pkg::*;

    logic [PERIPH_SEL_W-1:0] sel_idx;
    logic                    sel_mapped;

    // slave select field of the address
    assign sel_idx    = paddr_i[PERIPH_SEL_LSB +: PERIPH_SEL_W];
    assign sel_mapped = (int'(sel_idx) < NUM_SLAVES);

    // shared request lines, slaves only see their own offset
    assign s_paddr_o   = paddr_i[PERIPH_OFFS_W-1:0];
    assign s_penable_o = penable_i;
    assign s_pwrite_o  = pwrite_i;
    assign s_pwdata_o  = pwdata_i;

    // one-hot slave select
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            s_psel_o[i] = psel_i && (int'(sel_idx) == i);
        end
    end

    // response mux back to the master
    always_comb begin
        prdata_o  = '0;
        pready_o  = 1'b0;
        pslverr_o = 1'b0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (s_psel_o[i]) begin
                prdata_o  = s_prdata_i[i];
                pready_o  = s_pready_i[i];
                pslverr_o = s_pslverr_i[i];
            end
        end
        // no slave there, finish at once with an error
        if (psel_i && !sel_mapped) begin
            pready_o  = penable_i;
            pslverr_o = penable_i;
        end
    end

endmodule : periph_xbar

`default_nettype wire

/* hw/platform_pkg.sv */
// peripheral bus widths, slave indices of the peripheral xbar
// and the address decode field
`default_nettype none

package platform_pkg;

    // apb peripheral bus
    localparam int PERIPH_AW = 12;
    localparam int PERIPH_DW = 32;

    // peripheral xbar slaves
    localparam int PERIPH_XBAR_NUM_SLAVES           = 3;
    localparam int PERIPH_XBAR_MTIMER_SLAVE_IDX     = 0;
    localparam int PERIPH_XBAR_LED_DRIVER_SLAVE_IDX = 1;
    localparam int PERIPH_XBAR_UART_SLAVE_IDX       = 2;

    // paddr[9:8] picks the slave
    // select values 0 to 2 are slaves, 3 has no slave behind it
    localparam int PERIPH_SEL_LSB = 8;
    localparam int PERIPH_SEL_W   = 2;

    // register offset inside one slave
    localparam int PERIPH_OFFS_W = 8;

endpackage : platform_pkg

`default_nettype wire

/* hw/uart_tx.sv */
// apb-programmed 8N1 uart transmitter with baud divider and busy flag
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int unsigned DEFAULT_BAUD_DIV = 868
) (
    input  wire                                    clk_i,
    input  wire                                    reset_i,

    // apb slave
    input  wire                                    psel_i,
    input  wire                                    penable_i,
    input  wire                                    pwrite_i,
    input  wire  [platform_pkg::PERIPH_OFFS_W-1:0] paddr_i,
    input  wire  [platform_pkg::PERIPH_DW-1:0]     pwdata_i,
    output logic [platform_pkg::PERIPH_DW-1:0]     prdata_o,
    output logic                                   pready_o,
    output logic                                   pslverr_o,

    output logic                                   uart_tx_o
);

    import periph_regs_pkg::*;

    logic        access;
    logic        wr_en;
    logic        offs_valid;
    logic        data_wr;
    logic        frame_start;
    logic        bit_end;
    logic        busy_q;
    logic [9:0]  shift_q;
    logic [3:0]  bit_cnt_q;
    logic [15:0] baud_cnt_q;
    logic [15:0] bit_len_q;
    logic [15:0] baud_div_q;

    assign access   = psel_i & penable_i;
    assign wr_en    = access & pwrite_i;
    assign pready_o = access;

    // data written while a frame runs is dropped
    assign data_wr     = wr_en && (paddr_i == UART_DATA_OFFS);
    assign frame_start = data_wr && !busy_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            baud_div_q <= 16'(DEFAULT_BAUD_DIV);
        end else if (wr_en && paddr_i == UART_BAUD_OFFS) begin
            baud_div_q <= pwdata_i[15:0];
        end
    end

    // bit length frozen for the whole frame
    always_ff @(posedge clk_i) begin
        if (frame_start) begin
            bit_len_q <= baud_div_q;
        end
    end

    assign bit_end = (baud_cnt_q == bit_len_q - 16'd1);

    // stop, data lsb first, start; ones shift in behind the frame
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q     <= 1'b0;
            shift_q    <= '1;
            bit_cnt_q  <= '0;
            baud_cnt_q <= '0;
        end else if (frame_start) begin
            busy_q     <= 1'b1;
            shift_q    <= {1'b1, pwdata_i[7:0], 1'b0};
            bit_cnt_q  <= '0;
            baud_cnt_q <= '0;
        end else if (busy_q) begin
            if (bit_end) begin
                baud_cnt_q <= '0;
                shift_q    <= {1'b1, shift_q[9:1]};
                bit_cnt_q  <= bit_cnt_q + 4'd1;
                // stop bit done
                if (bit_cnt_q == 4'd9) begin
                    busy_q <= 1'b0;
                end
            end else begin
                baud_cnt_q <= baud_cnt_q + 16'd1;
            end
        end
    end

    assign uart_tx_o = shift_q[0];

    // read mux, data register reads as zero
    always_comb begin
        prdata_o   = '0;
        offs_valid = 1'b1;
        case (paddr_i)
            UART_DATA_OFFS:   prdata_o = '0;
            UART_STATUS_OFFS: prdata_o[UART_STATUS_BUSY_BIT] = busy_q;
            UART_BAUD_OFFS:   prdata_o[15:0] = baud_div_q;
            default:          offs_valid = 1'b0;
        endcase
    end

    assign pslverr_o = (access & ~offs_valid) | (data_wr & busy_q);

endmodule : uart_tx

`default_nettype wire

/* hw/yarc_periph_top.sv */
// peripheral top level: apb decoder with machine timer,
// led driver and uart transmitter behind it
`timescale 1ns/1ps
`default_nettype none

module yarc_periph_top #(
    parameter int unsigned TICK_DIV         = 10,
    parameter int unsigned DEFAULT_BAUD_DIV = 868
) (
    input  wire                                 clk_i,
    input  wire                                 reset_i,

    // apb slave port
    input  wire  [platform_pkg::PERIPH_AW-1:0]  paddr_i,
    input  wire                                 psel_i,
    input  wire                                 penable_i,
    input  wire                                 pwrite_i,
    input  wire  [platform_pkg::PERIPH_DW-1:0]  pwdata_i,
    output logic [platform_pkg::PERIPH_DW-1:0]  prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,

    // peripheral lines
    output logic [7:0]                          led_status_o,
    output logic                                uart_tx_o,
    output logic                                timer_int_o
);

    import platform_pkg::*;

    // routed bus between xbar and slaves
    logic [PERIPH_XBAR_NUM_SLAVES-1:0]                s_psel;
    logic [PERIPH_OFFS_W-1:0]                         s_paddr;
    logic                                             s_penable;
    logic                                             s_pwrite;
    logic [PERIPH_DW-1:0]                             s_pwdata;
    logic [PERIPH_XBAR_NUM_SLAVES-1:0][PERIPH_DW-1:0] s_prdata;
    logic [PERIPH_XBAR_NUM_SLAVES-1:0]                s_pready;
    logic [PERIPH_XBAR_NUM_SLAVES-1:0]                s_pslverr;

    periph_xbar #(.NUM_SLAVES(PERIPH_XBAR_NUM_SLAVES)) periph_xbar_i (
        .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .s_psel_o(s_psel), .s_paddr_o(s_paddr), .s_penable_o(s_penable),
        .s_pwrite_o(s_pwrite), .s_pwdata_o(s_pwdata),
        .s_prdata_i(s_prdata), .s_pready_i(s_pready), .s_pslverr_i(s_pslverr)
    );

    // machine timer
    mtimer #(.TICK_DIV(TICK_DIV)) mtimer_i (
        .clk_i(clk_i), .reset_i(reset_i),
        .psel_i(s_psel[PERIPH_XBAR_MTIMER_SLAVE_IDX]), .penable_i(s_penable),
        .pwrite_i(s_pwrite), .paddr_i(s_paddr), .pwdata_i(s_pwdata),
        .prdata_o(s_prdata[PERIPH_XBAR_MTIMER_SLAVE_IDX]),
        .pready_o(s_pready[PERIPH_XBAR_MTIMER_SLAVE_IDX]),
        .pslverr_o(s_pslverr[PERIPH_XBAR_MTIMER_SLAVE_IDX]),
        .timer_int_o(timer_int_o)
    );

    // led driver
    led_driver led_driver_i (
        .clk_i(clk_i), .reset_i(reset_i),
        .psel_i(s_psel[PERIPH_XBAR_LED_DRIVER_SLAVE_IDX]), .penable_i(s_penable),
        .pwrite_i(s_pwrite), .paddr_i(s_paddr), .pwdata_i(s_pwdata),
        .prdata_o(s_prdata[PERIPH_XBAR_LED_DRIVER_SLAVE_IDX]),
        .pready_o(s_pready[PERIPH_XBAR_LED_DRIVER_SLAVE_IDX]),
        .pslverr_o(s_pslverr[PERIPH_XBAR_LED_DRIVER_SLAVE_IDX]),
        .led_status_o(led_status_o)
    );

    // uart transmitter
    uart_tx #(.DEFAULT_BAUD_DIV(DEFAULT_BAUD_DIV)) uart_tx_i (
        .clk_i(clk_i), .reset_i(reset_i),
        .psel_i(s_psel[PERIPH_XBAR_UART_SLAVE_IDX]), .penable_i(s_penable),
        .pwrite_i(s_pwrite), .paddr_i(s_paddr), .pwdata_i(s_pwdata),
        .prdata_o(s_prdata[PERIPH_XBAR_UART_SLAVE_IDX]),
        .pready_o(s_pready[PERIPH_XBAR_UART_SLAVE_IDX]),
        .pslverr_o(s_pslverr[PERIPH_XBAR_UART_SLAVE_IDX]),
        .uart_tx_o(uart_tx_o)
    );

endmodule : yarc_periph_top

`default_nettype wire

/* testbench/tb_yarc_periph_top.sv */
// directed tests for the peripheral top level: apb driver tasks,
// lfsr stimulus, uart receiver, value check and summary
`timescale 1ns/1ps
`default_nettype none

module tb_yarc_periph_top;

    import platform_pkg::*;
    import periph_regs_pkg::*;

    localparam int TICK_DIV     = 1;
    localparam int BAUD_DIV     = 16;
    localparam int XFER_TIMEOUT = 16;
    localparam int POLL_TIMEOUT = 200;

    localparam logic [1:0] MTIMER_SEL   = 2'(PERIPH_XBAR_MTIMER_SLAVE_IDX);
    localparam logic [1:0] LED_SEL      = 2'(PERIPH_XBAR_LED_DRIVER_SLAVE_IDX);
    localparam logic [1:0] UART_SEL     = 2'(PERIPH_XBAR_UART_SLAVE_IDX);
    localparam logic [1:0] UNMAPPED_SEL = 2'd3;

    logic                 clk;
    logic                 reset;
    logic [PERIPH_AW-1:0] paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [PERIPH_DW-1:0] pwdata;
    logic [PERIPH_DW-1:0] prdata;
    logic                 pready;
    logic                 pslverr;
    logic [7:0]           led_status;
    logic                 uart_tx;
    logic                 timer_int;

    int          errors;
    int          checks;
    logic [31:0] lfsr_state;

    yarc_periph_top #(
        .TICK_DIV(TICK_DIV),
        .DEFAULT_BAUD_DIV(BAUD_DIV)
    ) yarc_periph_top_i (
        .clk_i(clk), .reset_i(reset),
        .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
        .pwrite_i(pwrite), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
        .led_status_o(led_status), .uart_tx_o(uart_tx), .timer_int_o(timer_int)
    );

    always #4 clk = ~clk;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [PERIPH_AW-1:0] periph_addr(input logic [1:0] sel,
                                                         input logic [7:0] offs);
        return {2'b00, sel, offs};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s got 0x%08h expected 0x%08h",
                     $time, name, got, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("%0t ns gave up waiting for %s", $time, what);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s finished with %0d errors", name, errors - errs_before);
    endtask

    // one transfer: setup, then access until pready
    task automatic apb_xfer(input logic is_write, input logic [PERIPH_AW-1:0] addr,
                            input logic [PERIPH_DW-1:0] wdata,
                            output logic [PERIPH_DW-1:0] rdata, output logic slverr);
        int   waits;
        logic done;
        waits  = 0;
        done   = 1'b0;
        rdata  = 'x;
        slverr = 1'bx;
        @(negedge clk);
        paddr   = addr;
        pwrite  = is_write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        while (!done && waits < XFER_TIMEOUT) begin
            // response has settled well before the rising edge
            #1;
            if (pready === 1'b1) begin
                rdata  = prdata;
                slverr = pslverr;
                done   = 1'b1;
                // every slave answers in the first access cycle
                check_value("pready_o wait states", 32'(waits), 32'd0);
            end
            @(negedge clk);
            waits++;
        end
        if (!done) begin
            report_timeout("pready");
        end
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [PERIPH_AW-1:0] addr,
                             input logic [PERIPH_DW-1:0] data, output logic slverr);
        logic [PERIPH_DW-1:0] unused_rdata;
        apb_xfer(1'b1, addr, data, unused_rdata, slverr);
    endtask

    task automatic apb_read(input logic [PERIPH_AW-1:0] addr,
                            output logic [PERIPH_DW-1:0] data, output logic slverr);
        apb_xfer(1'b0, addr, '0, data, slverr);
    endtask

    // samples each bit in its middle, counted from the falling edges
    task automatic receive_frame(input int baud, output logic [7:0] data,
                                 output logic stop_bit, output logic got);
        int waits;
        waits    = 0;
        data     = '0;
        stop_bit = 1'b0;
        got      = 1'b0;
        while (uart_tx !== 1'b0 && waits < POLL_TIMEOUT) begin
            @(negedge clk);
            waits++;
        end
        if (uart_tx !== 1'b0) begin
            report_timeout("uart start bit");
        end else begin
            repeat (baud / 2) @(negedge clk);
            check_value("uart_tx_o start bit", 32'(uart_tx), 32'd0);
            for (int i = 0; i < 8; i++) begin
                repeat (baud) @(negedge clk);
                data[i] = uart_tx;
            end
            repeat (baud) @(negedge clk);
            stop_bit = uart_tx;
            got      = 1'b1;
        end
    endtask

    task automatic wait_uart_idle();
        logic [31:0] status;
        logic        err;
        int          reads;
        reads  = 0;
        status = 32'd1 << UART_STATUS_BUSY_BIT;
        while (status[UART_STATUS_BUSY_BIT] !== 1'b0 && reads < POLL_TIMEOUT) begin
            apb_read(periph_addr(UART_SEL, UART_STATUS_OFFS), status, err);
            reads++;
        end
        if (status[UART_STATUS_BUSY_BIT] !== 1'b0) begin
            report_timeout("uart busy to fall");
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] rd;
        logic        err;
        int          errs_before;
        errs_before = errors;
        check_value("led_status_o", 32'(led_status), 32'd0);
        check_value("uart_tx_o", 32'(uart_tx), 32'd1);
        check_value("timer_int_o", 32'(timer_int), 32'd0);
        apb_read(periph_addr(UNMAPPED_SEL, 8'h00), rd, err);
        check_value("pslverr_o unmapped", 32'(err), 32'd1);
        check_value("prdata_o unmapped", rd, 32'd0);
        apb_read(periph_addr(UART_SEL, UART_BAUD_OFFS), rd, err);
        check_value("uart baud after reset", rd, 32'(BAUD_DIV));
        report_test("reset state", errs_before);
    endtask

    task automatic test_led_register();
        logic [31:0] rnd;
        logic [31:0] rd;
        logic [7:0]  expected;
        logic        err;
        int          errs_before;
        errs_before = errors;
        take_bits(8, rnd);
        expected = rnd[7:0];
        apb_write(periph_addr(LED_SEL, LED_OUT_OFFS), rnd, err);
        check_value("pslverr_o led out", 32'(err), 32'd0);
        check_value("led_status_o after out", 32'(led_status), 32'(expected));
        apb_read(periph_addr(LED_SEL, LED_OUT_OFFS), rd, err);
        check_value("led out readback", rd, 32'(expected));
        // set by ones
        take_bits(8, rnd);
        expected = expected | rnd[7:0];
        apb_write(periph_addr(LED_SEL, LED_SET_OFFS), rnd, err);
        check_value("led_status_o after set", 32'(led_status), 32'(expected));
        apb_read(periph_addr(LED_SEL, LED_SET_OFFS), rd, err);
        check_value("led set readback", rd, 32'(expected));
        // clear by ones
        take_bits(8, rnd);
        expected = expected & ~rnd[7:0];
        apb_write(periph_addr(LED_SEL, LED_CLR_OFFS), rnd, err);
        check_value("led_status_o after clear", 32'(led_status), 32'(expected));
        apb_read(periph_addr(LED_SEL, LED_CLR_OFFS), rd, err);
        check_value("led clear readback", rd, 32'(expected));
        report_test("led register", errs_before);
    endtask

    task automatic test_timer_interrupt();
        logic [31:0] rd;
        logic        err;
        int          reads;
        int          waits;
        int          errs_before;
        errs_before = errors;
        apb_write(periph_addr(MTIMER_SEL, MTIME_LO_OFFS), 32'd0, err);
        apb_write(periph_addr(MTIMER_SEL, MTIME_HI_OFFS), 32'd0, err);
        apb_write(periph_addr(MTIMER_SEL, MTIMECMP_LO_OFFS), 32'd200, err);
        apb_write(periph_addr(MTIMER_SEL, MTIMECMP_HI_OFFS), 32'd0, err);
        apb_read(periph_addr(MTIMER_SEL, MTIMECMP_LO_OFFS), rd, err);
        check_value("mtimecmp low readback", rd, 32'd200);
        reads = 0;
        rd    = '0;
        while (rd < 32'd199 && reads < POLL_TIMEOUT) begin
            apb_read(periph_addr(MTIMER_SEL, MTIME_LO_OFFS), rd, err);
            if (rd < 32'd199) begin
                check_value("timer_int_o below compare", 32'(timer_int), 32'd0);
            end
            reads++;
        end
        if (rd < 32'd199) begin
            report_timeout("mtime to reach 199");
        end
        waits = 0;
        while (timer_int !== 1'b1 && waits < POLL_TIMEOUT) begin
            @(negedge clk);
            waits++;
        end
        if (timer_int !== 1'b1) begin
            report_timeout("timer_int_o to rise");
        end
        apb_write(periph_addr(MTIMER_SEL, MTIMECMP_HI_OFFS), 32'hFFFF_FFFF, err);
        // compare is registered, one more clock
        @(negedge clk);
        check_value("timer_int_o after compare raised", 32'(timer_int), 32'd0);
        apb_write(periph_addr(MTIMER_SEL, MTIME_LO_OFFS), 32'h0001_0000, err);
        apb_read(periph_addr(MTIMER_SEL, MTIME_LO_OFFS), rd, err);
        check_value("mtime low not below written", 32'(rd >= 32'h0001_0000), 32'd1);
        report_test("timer interrupt", errs_before);
    endtask

    task automatic uart_frame_check(input int baud);
        logic [31:0] rnd;
        logic [7:0]  rx_byte;
        logic        stop_bit;
        logic        got;
        logic        err;
        take_bits(8, rnd);
        fork
            apb_write(periph_addr(UART_SEL, UART_DATA_OFFS), 32'(rnd[7:0]), err);
            receive_frame(baud, rx_byte, stop_bit, got);
        join
        check_value("pslverr_o uart data", 32'(err), 32'd0);
        check_value("uart frame received", 32'(got), 32'd1);
        check_value("uart data byte", 32'(rx_byte), 32'(rnd[7:0]));
        check_value("uart stop bit", 32'(stop_bit), 32'd1);
        wait_uart_idle();
    endtask

    task automatic test_uart_frames();
        logic [31:0] rd;
        logic        err;
        int          errs_before;
        errs_before = errors;
        uart_frame_check(BAUD_DIV);
        apb_write(periph_addr(UART_SEL, UART_BAUD_OFFS), 32'd8, err);
        apb_read(periph_addr(UART_SEL, UART_BAUD_OFFS), rd, err);
        check_value("uart baud readback", rd, 32'd8);
        uart_frame_check(8);
        report_test("uart frames", errs_before);
    endtask

    task automatic test_uart_backpressure();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] status;
        logic [7:0]  rx_byte;
        logic        stop_bit;
        logic        got;
        logic        err_first;
        logic        err_second;
        logic        err;
        int          lows;
        int          errs_before;
        errs_before = errors;
        lows = 0;
        take_bits(8, first);
        take_bits(8, second);
        fork
            begin
                apb_write(periph_addr(UART_SEL, UART_DATA_OFFS), 32'(first[7:0]), err_first);
                apb_write(periph_addr(UART_SEL, UART_DATA_OFFS), 32'(second[7:0]), err_second);
                apb_read(periph_addr(UART_SEL, UART_STATUS_OFFS), status, err);
            end
            receive_frame(8, rx_byte, stop_bit, got);
        join
        check_value("pslverr_o first write", 32'(err_first), 32'd0);
        check_value("pslverr_o second write", 32'(err_second), 32'd1);
        check_value("uart busy during frame", 32'(status[UART_STATUS_BUSY_BIT]), 32'd1);
        check_value("uart frame received", 32'(got), 32'd1);
        check_value("uart first byte", 32'(rx_byte), 32'(first[7:0]));
        check_value("uart stop bit", 32'(stop_bit), 32'd1);
        wait_uart_idle();
        apb_read(periph_addr(UART_SEL, UART_STATUS_OFFS), status, err);
        check_value("uart busy after frame", 32'(status[UART_STATUS_BUSY_BIT]), 32'd0);
        // dropped byte must never show up on the line
        repeat (10 * 8) begin
            @(negedge clk);
            if (uart_tx !== 1'b1) begin
                lows++;
            end
        end
        check_value("uart_tx_o low clocks after drop", 32'(lows), 32'd0);
        report_test("uart back-pressure", errs_before);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'd96434;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_led_register();
        test_timer_interrupt();
        test_uart_frames();
        test_uart_backpressure();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_yarc_periph_top

`default_nettype wire

/* yarc_periph_top.f */
hw/platform_pkg.sv
hw/periph_regs_pkg.sv
hw/periph_xbar.sv
hw/mtimer.sv
hw/led_driver.sv
hw/uart_tx.sv
hw/yarc_periph_top.sv
testbench/tb_yarc_periph_top.sv
